// File: hw/ddr_wr_pkg.sv
package ddr_wr_pkg;

  // byte address as seen by the host side
  localparam int BYTE_ADDR_W = 34;

  // one line is 16 bytes, so the line address drops the low 4 bits
  localparam int LINE_ADDR_W = BYTE_ADDR_W - 4;

  // controller command address, line address with a zero appended
  localparam int DDR_ADDR_W = LINE_ADDR_W + 1;

  localparam int HALVES_PER_LINE = 8;
  localparam int BYTES_PER_LINE  = 16;

  // 128-bit line word
  // halfword view for the write buffer, byte view for the line memory
  typedef union packed {
    logic [HALVES_PER_LINE-1:0][15:0] halves;
    logic [BYTES_PER_LINE-1:0][7:0]   bytes;
  } ddr_line_u;

endpackage

// File: hw/burst_writer.sv
`timescale 1ns/1ns

module burst_writer import ddr_wr_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cmd_start_i,
  input  logic [BYTE_ADDR_W-1:0] cmd_addr_i,
  input  logic [15:0]            cmd_count_i,
  input  logic [15:0]            host_data_i,
  input  logic [1:0]             host_sel_i,
  input  logic                   wr_ack_i,
  output logic                   host_take_o,
  output logic                   wr_strb_o,
  output logic [BYTE_ADDR_W-1:0] wr_addr_o,
  output logic [15:0]            wr_data_o,
  output logic [1:0]             wr_sel_o,
  output logic                   wr_eob_o,
  output logic                   busy_o,
  output logic                   done_o
);

  logic                   busy_q;
  logic                   eob_q;
  logic [15:0]            remain_q;
  logic [BYTE_ADDR_W-1:0] addr_q;
  logic                   start;
  logic                   take;
  logic                   last_take;

  // a zero count would never finish, so it is not accepted
  assign start = cmd_start_i & ~busy_q & (cmd_count_i != 16'd0);

  // strobe is a level while halfwords remain
  assign wr_strb_o = busy_q & (remain_q != 16'd0);
  assign take      = wr_strb_o & wr_ack_i;
  assign last_take = take & (remain_q == 16'd1);

  // host holds its halfword until the take pulse
  assign host_take_o = take;
  assign wr_addr_o   = addr_q;
  assign wr_data_o   = host_data_i;
  assign wr_sel_o    = host_sel_i;

  assign wr_eob_o = eob_q;
  assign done_o   = eob_q;
  assign busy_o   = busy_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q   <= 1'b0;
      eob_q    <= 1'b0;
      remain_q <= 16'd0;
    end else begin
      eob_q <= last_take;
      if (start) begin
        busy_q   <= 1'b1;
        remain_q <= cmd_count_i;
      end else if (take) begin
        remain_q <= remain_q - 16'd1;
        if (last_take) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // address counter steps one halfword per take
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= cmd_addr_i;
    end else if (take) begin
      addr_q <= addr_q + BYTE_ADDR_W'(2);
    end
  end

  // a held write must not move until the buffer takes it
  a_hold_until_ack: assert property (@(posedge clk) disable iff (reset)
    wr_strb_o && !wr_ack_i |=> wr_strb_o && $stable(wr_addr_o))
    else $error("burst_writer: write changed before it was acknowledged");

endmodule

// File: hw/mem_wr_cache.sv
`timescale 1ns/1ns

module mem_wr_cache import ddr_wr_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [1:0]             wr_sel_i,
  input  logic                   wr_strb_i,
  input  logic [BYTE_ADDR_W-1:0] wr_addr_i,
  input  logic [15:0]            wr_data_i,
  input  logic                   wr_eob,
  input  logic                   ddr_af_afull_i,
  input  logic                   ddr_df_afull_i,
  output logic                   wr_ack_o,
  output ddr_line_u              ddr_data_o,
  output logic [15:0]            ddr_mask_o,
  output logic                   ddr_data_wen_o,
  output logic [DDR_ADDR_W-1:0]  ddr_addr_o,
  output logic                   ddr_addr_wen_o,
  output logic                   empty_o
);

  localparam int HALF_IDX_W = $clog2(HALVES_PER_LINE);

  localparam logic SEND_IDLE   = 1'b0;
  localparam logic SEND_SECOND = 1'b1;

  // line buffer
  logic                   buf_empty_q;
  logic [LINE_ADDR_W-1:0] buf_addr_q;
  ddr_line_u              buf_line_q;
  logic [15:0]            buf_mask_q;

  // deferred work while the send path is occupied
  logic delayed_send_q;
  logic commit_send_q;

  // send sequencer
  logic                   send_q;
  logic [LINE_ADDR_W-1:0] sent_addr_q;
  logic                   send_busy;
  logic                   send_wait;
  logic                   send_free;
  logic                   start_send;

  logic [HALF_IDX_W-1:0]  half_idx;
  logic [LINE_ADDR_W-1:0] wr_line_addr;
  logic                   buf_hit;
  logic [15:0]            mask_overlay;
  ddr_line_u              line_fresh;
  ddr_line_u              line_merge;

  assign half_idx     = wr_addr_i[HALF_IDX_W:1];
  assign wr_line_addr = wr_addr_i[BYTE_ADDR_W-1:4];
  // an empty buffer accepts any line
  assign buf_hit      = buf_empty_q | (buf_addr_q == wr_line_addr);
  assign mask_overlay = {14'd0, wr_sel_i} << (2 * half_idx);

  always_comb begin
    line_fresh = '0;
    line_fresh.halves[half_idx] = wr_data_i;
  end

  // merge only the selected bytes of the addressed halfword
  always_comb begin
    line_merge = buf_line_q;
    line_merge.halves[half_idx] = {
      wr_sel_i[1] ? wr_data_i[15:8] : buf_line_q.halves[half_idx][15:8],
      wr_sel_i[0] ? wr_data_i[7:0]  : buf_line_q.halves[half_idx][7:0]
    };
  end

  assign send_busy = (send_q == SEND_SECOND);
  assign send_wait = send_busy ? (ddr_af_afull_i | ddr_df_afull_i) : ddr_df_afull_i;
  assign send_free = ~send_busy & ~send_wait;

  always_comb begin
    if (commit_send_q) begin
      wr_ack_o = 1'b0;
    end else if (delayed_send_q) begin
      wr_ack_o = wr_strb_i & send_free;
    end else begin
      wr_ack_o = wr_strb_i & (buf_hit | send_free);
    end
  end

  // beat 1 leaves on a miss, at end of burst or for deferred work
  assign start_send = send_free & (commit_send_q |
                                   (delayed_send_q & ~buf_empty_q) |
                                   (wr_strb_i & ~buf_hit) |
                                   (wr_eob & ~buf_empty_q));

  assign ddr_data_wen_o = (send_busy & ~send_wait) | start_send;
  assign ddr_addr_wen_o = send_busy & ~send_wait;

  assign ddr_data_o = buf_line_q;
  assign ddr_mask_o = send_busy ? 16'd0 : buf_mask_q;
  assign ddr_addr_o = {sent_addr_q, 1'b0};

  assign empty_o = buf_empty_q & ~delayed_send_q & ~commit_send_q & ~send_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_empty_q    <= 1'b1;
      buf_mask_q     <= 16'd0;
      delayed_send_q <= 1'b0;
      commit_send_q  <= 1'b0;
    end else if (commit_send_q) begin
      if (send_free) begin
        commit_send_q <= 1'b0;
        buf_empty_q   <= 1'b1;
        buf_mask_q    <= 16'd0;
      end
      if (wr_strb_i) begin
        delayed_send_q <= 1'b1;
      end
    end else if (delayed_send_q) begin
      if (send_free) begin
        delayed_send_q <= 1'b0;
        buf_empty_q    <= 1'b0;
        buf_addr_q     <= wr_line_addr;
        buf_line_q     <= line_fresh;
        buf_mask_q     <= mask_overlay;
      end
    end else if (wr_strb_i) begin
      if (buf_hit) begin
        buf_empty_q <= 1'b0;
        buf_addr_q  <= wr_line_addr;
        buf_line_q  <= line_merge;
        buf_mask_q  <= buf_mask_q | mask_overlay;
      end else if (send_busy | send_wait) begin
        delayed_send_q <= 1'b1;
      end else begin
        // old line goes out as beat 1 in this same cycle
        buf_addr_q <= wr_line_addr;
        buf_line_q <= line_fresh;
        buf_mask_q <= mask_overlay;
      end
    end else if (wr_eob && !buf_empty_q) begin
      if (send_busy | send_wait) begin
        commit_send_q <= 1'b1;
      end else begin
        buf_empty_q <= 1'b1;
        buf_mask_q  <= 16'd0;
      end
    end
  end

  // line address is captured with beat 1 since the buffer may refill
  always_ff @(posedge clk) begin
    if (reset) begin
      send_q <= SEND_IDLE;
    end else if (!send_busy && ddr_data_wen_o) begin
      send_q      <= SEND_SECOND;
      sent_addr_q <= buf_addr_q;
    end else if (send_busy && ddr_addr_wen_o) begin
      send_q <= SEND_IDLE;
    end
  end

  // the address push follows beat 1 directly or a stalled second beat
  a_addr_in_second: assert property (@(posedge clk) disable iff (reset)
    ddr_addr_wen_o |-> $past(ddr_data_wen_o && !ddr_addr_wen_o) ||
                       $past(send_q == SEND_SECOND && !ddr_addr_wen_o))
    else $error("mem_wr_cache: address push outside the second send beat");

  a_data_not_afull: assert property (@(posedge clk) disable iff (reset)
    ddr_data_wen_o |-> !ddr_df_afull_i)
    else $error("mem_wr_cache: data push while the data queue is almost full");

endmodule

// File: hw/ddr_wr_queue.sv
`timescale 1ns/1ns

module ddr_wr_queue import ddr_wr_pkg::*; #(
  parameter int MEM_LINES_LOG2  = 6,
  parameter int FIFO_DEPTH_LOG2 = 4,
  parameter int AFULL_SLACK     = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  ddr_line_u                 ddr_data_i,
  input  logic [15:0]               ddr_mask_i,
  input  logic                      ddr_data_wen_i,
  input  logic [DDR_ADDR_W-1:0]     ddr_addr_i,
  input  logic                      ddr_addr_wen_i,
  input  logic                      drain_en_i,
  input  logic [MEM_LINES_LOG2-1:0] rd_addr_i,
  output logic                      ddr_af_afull_o,
  output logic                      ddr_df_afull_o,
  output logic                      queue_empty_o,
  output ddr_line_u                 rd_data_o
);

  localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;
  localparam int CNT_W      = FIFO_DEPTH_LOG2 + 1;

  localparam logic [CNT_W-1:0] CNT_ONE   = CNT_W'(1);
  localparam logic [CNT_W-1:0] CNT_TWO   = CNT_W'(2);
  localparam logic [CNT_W-1:0] CNT_FULL  = CNT_W'(FIFO_DEPTH);
  localparam logic [CNT_W-1:0] CNT_AFULL = CNT_W'(FIFO_DEPTH - AFULL_SLACK);

  localparam logic [FIFO_DEPTH_LOG2-1:0] PTR_ONE = FIFO_DEPTH_LOG2'(1);

  // fifo 0 holds addresses, fifo 1 holds data beats
  localparam int AF = 0;
  localparam int DF = 1;

  logic [1:0]                 push;
  logic [1:0]                 pop;
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q [2];
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q [2];
  logic [CNT_W-1:0]           count_q  [2];

  logic [DDR_ADDR_W-1:0] af_mem      [FIFO_DEPTH];
  ddr_line_u             df_line_mem [FIFO_DEPTH];
  logic [15:0]           df_mask_mem [FIFO_DEPTH];

  ddr_line_u line_mem [1 << MEM_LINES_LOG2];

  // drain engine, beat 1 is held while beat 2 is popped
  logic                      drain_q;
  logic                      drain_start;
  logic [DDR_ADDR_W-1:0]     drain_addr_q;
  ddr_line_u                 drain_line_q;
  logic [15:0]               drain_mask_q;
  logic [MEM_LINES_LOG2-1:0] mem_idx;
  ddr_line_u                 beat2_line;
  logic [15:0]               beat2_mask;

  assign push = {ddr_data_wen_i, ddr_addr_wen_i};

  // an address is only pushed with beat 2, so both beats are already queued
  assign drain_start = ~drain_q & drain_en_i &
                       (count_q[AF] != '0) & (count_q[DF] >= CNT_TWO);
  assign pop = {drain_start | drain_q, drain_start};

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int f = 0; f < 2; f++) begin
        wr_ptr_q[f] <= '0;
        rd_ptr_q[f] <= '0;
        count_q[f]  <= '0;
      end
    end else begin
      for (int f = 0; f < 2; f++) begin
        if (push[f]) begin
          wr_ptr_q[f] <= wr_ptr_q[f] + PTR_ONE;
        end
        if (pop[f]) begin
          rd_ptr_q[f] <= rd_ptr_q[f] + PTR_ONE;
        end
        if (push[f] && !pop[f]) begin
          count_q[f] <= count_q[f] + CNT_ONE;
        end else if (pop[f] && !push[f]) begin
          count_q[f] <= count_q[f] - CNT_ONE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push[AF]) begin
      af_mem[wr_ptr_q[AF]] <= ddr_addr_i;
    end
    if (push[DF]) begin
      df_line_mem[wr_ptr_q[DF]] <= ddr_data_i;
      df_mask_mem[wr_ptr_q[DF]] <= ddr_mask_i;
    end
  end

  assign ddr_af_afull_o = (count_q[AF] >= CNT_AFULL);
  assign ddr_df_afull_o = (count_q[DF] >= CNT_AFULL);
  assign queue_empty_o  = (count_q[AF] == '0) & (count_q[DF] == '0) & ~drain_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_q <= 1'b0;
    end else begin
      drain_q <= drain_start;
    end
  end

  always_ff @(posedge clk) begin
    if (drain_start) begin
      drain_addr_q <= af_mem[rd_ptr_q[AF]];
      drain_line_q <= df_line_mem[rd_ptr_q[DF]];
      drain_mask_q <= df_mask_mem[rd_ptr_q[DF]];
    end
  end

  assign beat2_line = df_line_mem[rd_ptr_q[DF]];
  assign beat2_mask = df_mask_mem[rd_ptr_q[DF]];
  // low line-address bits only, upper lines alias
  assign mem_idx    = drain_addr_q[MEM_LINES_LOG2:1];

  always_ff @(posedge clk) begin
    if (drain_q) begin
      for (int b = 0; b < BYTES_PER_LINE; b++) begin
        if (drain_mask_q[b]) begin
          line_mem[mem_idx].bytes[b] <= drain_line_q.bytes[b];
        end else if (beat2_mask[b]) begin
          line_mem[mem_idx].bytes[b] <= beat2_line.bytes[b];
        end
      end
    end
    rd_data_o <= line_mem[rd_addr_i];
  end

  for (genvar f = 0; f < 2; f++) begin : g_fifo_chk
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      push[f] |-> count_q[f] != CNT_FULL)
      else $error("ddr_wr_queue: push into full fifo %0d", f);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      pop[f] |-> count_q[f] != '0)
      else $error("ddr_wr_queue: pop from empty fifo %0d", f);
  end

endmodule

// File: hw/ddr_wr_top.sv
`timescale 1ns/1ns

module ddr_wr_top import ddr_wr_pkg::*; #(
  parameter int MEM_LINES_LOG2  = 6,
  parameter int FIFO_DEPTH_LOG2 = 4,
  parameter int AFULL_SLACK     = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmd_start_i,
  input  logic [BYTE_ADDR_W-1:0]    cmd_addr_i,
  input  logic [15:0]               cmd_count_i,
  input  logic [15:0]               host_data_i,
  input  logic [1:0]                host_sel_i,
  input  logic                      drain_en_i,
  input  logic [MEM_LINES_LOG2-1:0] rd_addr_i,
  output logic                      host_take_o,
  output logic                      busy_o,
  output logic                      done_o,
  output logic                      idle_o,
  output ddr_line_u                 rd_data_o
);

  // writer to buffer
  logic                   wr_strb;
  logic                   wr_ack;
  logic [BYTE_ADDR_W-1:0] wr_addr;
  logic [15:0]            wr_data;
  logic [1:0]             wr_sel;
  logic                   wr_eob;

  // buffer to controller queues
  ddr_line_u              ddr_data;
  logic [15:0]            ddr_mask;
  logic                   ddr_data_wen;
  logic [DDR_ADDR_W-1:0]  ddr_addr;
  logic                   ddr_addr_wen;
  logic                   af_afull;
  logic                   df_afull;

  logic cache_empty;
  logic queue_empty;

  burst_writer u_writer (
    .clk         (clk),
    .reset       (reset),
    .cmd_start_i (cmd_start_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_count_i (cmd_count_i),
    .host_data_i (host_data_i),
    .host_sel_i  (host_sel_i),
    .wr_ack_i    (wr_ack),
    .host_take_o (host_take_o),
    .wr_strb_o   (wr_strb),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_sel_o    (wr_sel),
    .wr_eob_o    (wr_eob),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  mem_wr_cache u_cache (
    .clk            (clk),
    .reset          (reset),
    .wr_sel_i       (wr_sel),
    .wr_strb_i      (wr_strb),
    .wr_addr_i      (wr_addr),
    .wr_data_i      (wr_data),
    .wr_eob         (wr_eob),
    .ddr_af_afull_i (af_afull),
    .ddr_df_afull_i (df_afull),
    .wr_ack_o       (wr_ack),
    .ddr_data_o     (ddr_data),
    .ddr_mask_o     (ddr_mask),
    .ddr_data_wen_o (ddr_data_wen),
    .ddr_addr_o     (ddr_addr),
    .ddr_addr_wen_o (ddr_addr_wen),
    .empty_o        (cache_empty)
  );

  ddr_wr_queue #(
    .MEM_LINES_LOG2  (MEM_LINES_LOG2),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .AFULL_SLACK     (AFULL_SLACK)
  ) u_queue (
    .clk            (clk),
    .reset          (reset),
    .ddr_data_i     (ddr_data),
    .ddr_mask_i     (ddr_mask),
    .ddr_data_wen_i (ddr_data_wen),
    .ddr_addr_i     (ddr_addr),
    .ddr_addr_wen_i (ddr_addr_wen),
    .drain_en_i     (drain_en_i),
    .rd_addr_i      (rd_addr_i),
    .ddr_af_afull_o (af_afull),
    .ddr_df_afull_o (df_afull),
    .queue_empty_o  (queue_empty),
    .rd_data_o      (rd_data_o)
  );

  // nothing left in flight anywhere between host and line memory
  assign idle_o = ~busy_o & cache_empty & queue_empty;

endmodule

// File: testbench/tb_ddr_wr.sv
`timescale 1ns/1ns

module tb_ddr_wr import ddr_wr_pkg::*; ();

  localparam int MEM_LINES_LOG2  = 6;
  localparam int FIFO_DEPTH_LOG2 = 4;
  localparam int AFULL_SLACK     = 2;
  localparam int MEM_LINES       = 1 << MEM_LINES_LOG2;
  localparam int MEM_BYTES       = MEM_LINES * BYTES_PER_LINE;
  localparam int WAIT_LIMIT      = 2000;
  // one line per flush that fits the data queue, plus the held line and one in the drain
  localparam int TAKE_BOUND = ((1 << FIFO_DEPTH_LOG2) / 2 + 2) * HALVES_PER_LINE;

  localparam int W_TAKE = 0;
  localparam int W_DONE = 1;
  localparam int W_IDLE = 2;
  localparam int W_FREE = 3;

  logic                      clk = 1'b0;
  logic                      reset = 1'b1;
  logic                      cmd_start_i;
  logic [BYTE_ADDR_W-1:0]    cmd_addr_i;
  logic [15:0]               cmd_count_i;
  logic [15:0]               host_data_i;
  logic [1:0]                host_sel_i;
  logic                      drain_en_i = 1'b1;
  logic [MEM_LINES_LOG2-1:0] rd_addr_i;
  logic                      host_take_o;
  logic                      busy_o;
  logic                      done_o;
  logic                      idle_o;
  ddr_line_u                 rd_data_o;

  // byte image of what the line memory should hold
  logic [7:0] ref_mem [MEM_BYTES];

  // read-back compare, the line memory answers one cycle after the address
  logic                      rd_req = 1'b0;
  ddr_line_u                 rd_exp;
  logic                      rd_chk_q = 1'b0;
  ddr_line_u                 rd_exp_q;
  logic [MEM_LINES_LOG2-1:0] rd_idx_q;

  // draining goes off for long stretches while throttle is set
  logic throttle = 1'b0;
  int   throttle_cnt = 0;
  int   off_takes = 0;
  logic afull_seen = 1'b0;

  always #4 clk = ~clk;

  ddr_wr_top #(
    .MEM_LINES_LOG2  (MEM_LINES_LOG2),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .AFULL_SLACK     (AFULL_SLACK)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .cmd_start_i (cmd_start_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_count_i (cmd_count_i),
    .host_data_i (host_data_i),
    .host_sel_i  (host_sel_i),
    .drain_en_i  (drain_en_i),
    .rd_addr_i   (rd_addr_i),
    .host_take_o (host_take_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .idle_o      (idle_o),
    .rd_data_o   (rd_data_o)
  );

  always @(negedge clk) begin
    if (throttle) begin
      throttle_cnt <= throttle_cnt + 1;
      // off for 240 of every 256 cycles
      drain_en_i   <= (throttle_cnt % 256) >= 240;
    end else begin
      throttle_cnt <= 0;
      drain_en_i   <= 1'b1;
    end
  end

  always @(posedge clk) begin
    rd_chk_q <= rd_req;
    rd_exp_q <= rd_exp;
    rd_idx_q <= rd_addr_i;
    if (drain_en_i) begin
      off_takes <= 0;
    end else if (host_take_o) begin
      off_takes <= off_takes + 1;
    end
    if (UUT.u_queue.ddr_df_afull_o && !drain_en_i) begin
      afull_seen <= 1'b1;
    end
  end

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  a_reset_state: assert property (@(posedge clk) $fell(reset) |->
    !host_take_o && !done_o && idle_o)
    else begin
      $display("** Error: after reset host_take_o=%h done_o=%h idle_o=%h, expected 0 0 1",
               $sampled(host_take_o), $sampled(done_o), $sampled(idle_o));
      stop_run();
    end

  a_line_match: assert property (@(posedge clk) rd_chk_q |-> rd_data_o == rd_exp_q)
    else begin
      $display("** Error: rd_data_o line %h = %h, expected %h",
               $sampled(rd_idx_q), $sampled(rd_data_o), $sampled(rd_exp_q));
      stop_run();
    end

  a_take_bound: assert property (@(posedge clk) disable iff (reset)
    !drain_en_i && host_take_o |-> off_takes < TAKE_BOUND)
    else begin
      $display("host kept being served with draining off, %0d takes so far",
               $sampled(off_takes));
      stop_run();
    end

  task automatic wait_for(input int what, input string label);
    logic hit;
    for (int n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk);
      case (what)
        W_TAKE:  hit = host_take_o;
        W_DONE:  hit = done_o;
        W_IDLE:  hit = idle_o;
        default: hit = !busy_o;
      endcase
      if (hit) begin
        return;
      end
    end
    $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, label);
    stop_run();
  endtask

  function automatic int rand_base(input int count, input int span);
    return 2 * int'($urandom_range((span - 2 * count) / 2, 0));
  endfunction

  // one command, then one halfword per take pulse, then done
  task automatic run_burst(input int base, input int count, input bit rand_sel);
    logic [15:0] data;
    logic [1:0]  sel;
    int          addr;
    wait_for(W_FREE, "writer not busy");
    data = 16'($urandom);
    sel  = rand_sel ? 2'($urandom) : 2'b11;
    @(negedge clk);
    cmd_start_i = 1'b1;
    cmd_addr_i  = BYTE_ADDR_W'(base);
    cmd_count_i = 16'(count);
    host_data_i = data;
    host_sel_i  = sel;
    @(negedge clk);
    cmd_start_i = 1'b0;
    for (int i = 0; i < count; i++) begin
      wait_for(W_TAKE, "host_take_o");
      addr = base + 2 * i;
      if (sel[0]) begin
        ref_mem[addr] = data[7:0];
      end
      if (sel[1]) begin
        ref_mem[addr + 1] = data[15:8];
      end
      data = 16'($urandom);
      sel  = rand_sel ? 2'($urandom) : 2'b11;
      @(negedge clk);
      host_data_i = data;
      host_sel_i  = sel;
    end
    wait_for(W_DONE, "done_o");
  endtask

  task automatic check_lines(input int first, input int last);
    for (int l = first; l <= last; l++) begin
      @(negedge clk);
      rd_addr_i = MEM_LINES_LOG2'(l);
      for (int b = 0; b < BYTES_PER_LINE; b++) begin
        rd_exp.bytes[b] = ref_mem[l * BYTES_PER_LINE + b];
      end
      rd_req = 1'b1;
    end
    @(negedge clk);
    rd_req = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  initial begin
    int base;
    int count;
    void'($urandom(32'h9e625c45));
    cmd_start_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_count_i = '0;
    host_data_i = '0;
    host_sel_i  = '0;
    rd_addr_i   = '0;
    rd_exp      = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // one aligned line, merged by hits and flushed at end of burst
    run_burst(4 * BYTES_PER_LINE, HALVES_PER_LINE, 1'b0);
    wait_for(W_IDLE, "idle_o");
    check_lines(4, 4);

    // give every byte of the line memory a known value
    run_burst(0, MEM_BYTES / 2, 1'b0);
    wait_for(W_IDLE, "idle_o");
    check_lines(0, MEM_LINES - 1);

    // byte selects, unselected bytes keep their old value
    for (int k = 0; k < 12; k++) begin
      count = int'($urandom_range(24, 1));
      base  = rand_base(count, MEM_BYTES);
      run_burst(base, count, 1'b1);
    end
    wait_for(W_IDLE, "idle_o");
    check_lines(0, MEM_LINES - 1);

    // short bursts packed into 16 lines so lines get revisited
    for (int k = 0; k < 40; k++) begin
      count = int'($urandom_range(20, 1));
      base  = rand_base(count, 16 * BYTES_PER_LINE);
      run_burst(base, count, ($urandom & 1) != 0);
    end
    wait_for(W_IDLE, "idle_o");
    check_lines(0, MEM_LINES - 1);

    // long bursts against stalled queues
    throttle = 1'b1;
    for (int k = 0; k < 10; k++) begin
      count = int'($urandom_range(96, 32));
      base  = rand_base(count, MEM_BYTES);
      run_burst(base, count, ($urandom & 1) != 0);
    end
    throttle = 1'b0;
    wait_for(W_IDLE, "idle_o");
    check_lines(0, MEM_LINES - 1);

    // single halfword in the middle of a line
    run_burst(26 * BYTES_PER_LINE + 6, 1, 1'b0);
    wait_for(W_IDLE, "idle_o");
    check_lines(26, 26);

    if (afull_seen) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("data queue never reached almost-full while draining was off");
      stop_run();
    end
  end

endmodule

// File: src.f
hw/ddr_wr_pkg.sv
hw/burst_writer.sv
hw/mem_wr_cache.sv
hw/ddr_wr_queue.sv
hw/ddr_wr_top.sv
testbench/tb_ddr_wr.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ddr_wr
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   compile with Verilator and run the testbench"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "  help   list these targets"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR TOP FILELIST BUILD_DIR VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
